/* Makefile */
# Verilator simulation of the Z80 clock subsystem

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_zclk
FILELIST  = zclk.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* common/zclk_pkg.sv */
// turbo mode type and bus phase index type for the Z80 clock subsystem
package zclk_pkg;

	// Z80 clock speed as seen on the turbo port
	// both 1x codes select 14 MHz
	typedef enum logic [1:0]
	{
		TURBO_35   = 2'b00,
		TURBO_70   = 2'b01,
		TURBO_140  = 2'b10,
		TURBO_140B = 2'b11
	} turbo_t;

	// index of the current bus phase
	// 0 is c0, 3 is c3
	typedef logic [1:0] phase_t;

endpackage

/* common/zclk_settings.svh */
// phase count and external I/O wait window macros for the Z80 clock subsystem
`ifndef ZCLK_SETTINGS_SVH
`define ZCLK_SETTINGS_SVH

// fclk cycles per bus cycle, one per strobe c0..c3
`define ZCLK_PHASES 4

// length of the 14 MHz external I/O wait window in fclk cycles
`define ZCLK_IOWAIT_LEN 8

// stall value per window count, bit 0 is the first count
// counts 0..4 and 6 hold the stall
// counts 5 and 7 let one 14 MHz edge through
`define ZCLK_IOWAIT_PAT 8'b0101_1111

`endif

/* hdl/clk_phase.sv */
// four-phase bus sequencer producing the one-hot strobes c0 to c3
`timescale 1ns/1ps
`include "zclk_settings.svh"

module clk_phase
(
	input  logic fclk,
	input  logic rst_n,

	output logic c0,
	output logic c1,
	output logic c2,
	output logic c3
);

	import zclk_pkg::*;

	// current phase, restarts at c0 out of reset
	phase_t phase;

	// free running, wraps after the last phase
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= '0;
		else if (phase == phase_t'(`ZCLK_PHASES - 1))
			phase <= '0;
		else
			phase <= phase + phase_t'(1);
	end

	// one-hot decode
	// stands in for the arbiter and DRAM controller cycle timing
	assign c0 = (phase == 2'd0);
	assign c1 = (phase == 2'd1);
	assign c2 = (phase == 2'd2);
	assign c3 = (phase == 2'd3);

endmodule

/* hdl/zclk_top.sv */
// top level joining the phase sequencer, turbo switch, I/O wait generator and Z80 clock
`timescale 1ns/1ps

module zclk_top
(
	input  logic            fclk,
	input  logic            rst_n,

	input  logic            rfsh_n,
	input  logic            zclk_stall,

	// external I/O wait qualifiers
	input  logic            iorq_n,
	input  logic            m1_n,
	input  logic            external_port,

	// speed change handshake
	input  zclk_pkg::turbo_t turbo,
	input  logic            turbo_req,
	output logic            turbo_ack,

	output logic            zpos,
	output logic            zneg,
	output logic            zclk_out
);

	import zclk_pkg::*;

	logic   c0;
	logic   c2;
	logic   io_wait;
	// mode actually in use, switched at RFSH
	turbo_t int_turbo;

	// c1 and c3 have no user here
	clk_phase i_clk_phase
	(
		.fclk  (fclk),
		.rst_n (rst_n),
		.c0    (c0),
		.c1    (),
		.c2    (c2),
		.c3    ()
	);

	turbo_switch i_turbo_switch
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.zpos      (zpos),
		.rfsh_n    (rfsh_n),
		.turbo     (turbo),
		.turbo_req (turbo_req),
		.turbo_ack (turbo_ack),
		.int_turbo (int_turbo)
	);

	io_wait_gen i_io_wait_gen
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.zpos          (zpos),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.int_turbo     (int_turbo),
		.io_wait       (io_wait)
	);

	zclock i_zclock
	(
		.fclk       (fclk),
		.rst_n      (rst_n),
		.c0         (c0),
		.c2         (c2),
		.zclk_stall (zclk_stall),
		.io_wait    (io_wait),
		.int_turbo  (int_turbo),
		.zpos       (zpos),
		.zneg       (zneg),
		.zclk_out   (zclk_out)
	);

endmodule

/* test/tb_zclk.sv */
// testbench top with clock, reset, stimulus, turbo handshake driver and watchdog
`timescale 1ns/1ps

module tb_zclk;

	import zclk_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int TURBO_WAIT = 1000;
	// cycle budget of every test, summed for the watchdog
	localparam int BUDGET = 16 + 200 + 200 + 3 * (TURBO_WAIT + 100) + 400 + 4 * 70;

	logic            fclk;
	logic            rst_n;
	logic            rfsh_n;
	logic            zclk_stall;
	logic            iorq_n;
	logic            m1_n;
	logic            external_port;
	turbo_t          turbo;
	logic            turbo_req;
	logic            turbo_ack;
	logic            zpos;
	logic            zneg;
	logic            zclk_out;
	logic [8*12-1:0] test_name;
	logic            test_done;
	int              chk_errors;
	int              tb_errors;
	integer          seed;

	zclk_top i_zclk_top
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.rfsh_n        (rfsh_n),
		.zclk_stall    (zclk_stall),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.turbo         (turbo),
		.turbo_req     (turbo_req),
		.turbo_ack     (turbo_ack),
		.zpos          (zpos),
		.zneg          (zneg),
		.zclk_out      (zclk_out)
	);

	zclk_checker i_zclk_checker
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.rfsh_n        (rfsh_n),
		.zclk_stall    (zclk_stall),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.turbo         (turbo),
		.turbo_req     (turbo_req),
		.turbo_ack     (turbo_ack),
		.zpos          (zpos),
		.zneg          (zneg),
		.zclk_out      (zclk_out),
		.test_name     (test_name),
		.test_done     (test_done),
		.error_count   (chk_errors)
	);

	always #(CLK_PERIOD / 2) fclk = ~fclk;

	task automatic run_cycles(input int n);
		repeat (n) @(posedge fclk);
	endtask

	// one-cycle done pulse, the checker prints the line for the test
	task automatic end_test();
		test_done <= 1'b1;
		@(posedge fclk);
		test_done <= 1'b0;
		@(posedge fclk);
	endtask

	// four-phase request, RFSH toggles at random until the ack comes
	task automatic change_turbo(input turbo_t mode);
		int cnt;
		turbo <= mode;
		@(posedge fclk);
		turbo_req <= 1'b1;
		run_cycles(4);
		cnt = 0;
		while (!turbo_ack && cnt < TURBO_WAIT)
		begin
			if (($random(seed) % 6) == 0)
				rfsh_n <= ~rfsh_n;
			@(posedge fclk);
			cnt++;
		end
		if (!turbo_ack)
		begin
			$display("%0s: turbo_ack never rose for the requested mode", test_name);
			tb_errors++;
		end
		turbo_req <= 1'b0;
		rfsh_n <= 1'b1;
		cnt = 0;
		while (turbo_ack && cnt < 8)
		begin
			@(posedge fclk);
			cnt++;
		end
		if (turbo_ack)
		begin
			$display("%0s: turbo_ack did not drop after turbo_req", test_name);
			tb_errors++;
		end
		run_cycles(100);
	endtask

	task automatic io_cycle(input logic m1, input logic ext);
		m1_n <= m1;
		external_port <= ext;
		iorq_n <= 1'b0;
		run_cycles(24);
		iorq_n <= 1'b1;
		m1_n <= 1'b1;
		external_port <= 1'b0;
		run_cycles(36);
	endtask

	// ends a run that hangs
	initial
	begin
		#(BUDGET * 2 * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'h1d26_ffa5;
		tb_errors = 0;
		fclk = 1'b0;
		rst_n = 1'b0;
		rfsh_n = 1'b1;
		zclk_stall = 1'b0;
		iorq_n = 1'b1;
		m1_n = 1'b1;
		external_port = 1'b0;
		turbo = TURBO_35;
		turbo_req = 1'b0;
		test_name = "reset_35";
		test_done = 1'b0;
		run_cycles(16);
		rst_n <= 1'b1;
		run_cycles(200);
		end_test();

		// RFSH with nothing pending
		// a different mode waits on the port and must not be loaded
		test_name <= "rfsh_idle";
		turbo <= TURBO_70;
		repeat (200)
		begin
			if (($random(seed) % 6) == 0)
				rfsh_n <= ~rfsh_n;
			@(posedge fclk);
		end
		rfsh_n <= 1'b1;
		end_test();

		test_name <= "turbo_70";
		change_turbo(TURBO_70);
		end_test();

		test_name <= "turbo_140";
		change_turbo(TURBO_140);
		end_test();

		// roughly one cycle in four stalled
		test_name <= "stall_140";
		repeat (400)
		begin
			zclk_stall <= (($random(seed) & 3) == 0);
			@(posedge fclk);
		end
		zclk_stall <= 1'b0;
		end_test();

		test_name <= "io_140";
		io_cycle(1'b1, 1'b1);
		end_test();
		test_name <= "io_m1_140";
		io_cycle(1'b0, 1'b1);
		end_test();
		test_name <= "io_int_140";
		io_cycle(1'b1, 1'b0);
		end_test();

		test_name <= "turbo_back70";
		change_turbo(TURBO_70);
		end_test();
		test_name <= "io_70";
		io_cycle(1'b1, 1'b1);
		end_test();

		run_cycles(4);
		$display("summary: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* test/zclk_checker.sv */
// reference model, zpos and zneg interval measurement, handshake checks and per-test report
`timescale 1ns/1ps
`include "zclk_settings.svh"

module zclk_checker
(
	input  logic             fclk,
	input  logic             rst_n,
	input  logic             rfsh_n,
	input  logic             zclk_stall,
	input  logic             iorq_n,
	input  logic             m1_n,
	input  logic             external_port,
	input  zclk_pkg::turbo_t turbo,
	input  logic             turbo_req,
	input  logic             turbo_ack,
	input  logic             zpos,
	input  logic             zneg,
	input  logic             zclk_out,
	input  logic [8*12-1:0]  test_name,
	input  logic             test_done,
	output int               error_count
);

	import zclk_pkg::*;

	localparam logic [7:0] IOPAT = `ZCLK_IOWAIT_PAT;

	// mode the DUT should be running, tracked from the handshake
	turbo_t      mode;
	// interval after a mode switch is irregular, skip it
	logic        resync;
	// cycles since the last zpos and the stall seen in each of them
	int          since;
	logic [63:0] trace;
	// start of the last I/O wait window, in cycles relative to the last zpos
	int          io_at;
	logic        io_prev;
	logic        old_rfsh;
	logic        sw_seen;
	logic        prev_stall;
	logic        prev_req;
	logic        prev_ack;
	int          test_errs;
	int          test_checks;

	// expected distance from a zpos to the next zneg or zpos
	// at 14 MHz every unstalled cycle gives one edge, zneg first
	// io_at is the window start relative to that zpos
	function automatic int ref_gap(turbo_t m, logic [63:0] st, int io_at, logic to_zneg);
		logic s;
		int   k;
		int   zeros;
		int   want;
		zeros = 0;
		want = to_zneg ? 1 : 2;
		if (m == TURBO_35)
			return to_zneg ? `ZCLK_PHASES : 2 * `ZCLK_PHASES;
		if (m == TURBO_70)
			return to_zneg ? `ZCLK_PHASES / 2 : `ZCLK_PHASES;
		for (int i = 0; i < 64; i++)
		begin
			s = st[0];
			st = st >> 1;
			// the window pattern reaches the strobes two cycles after the start
			// and runs on past the zpos that follows it
			k = i - io_at - 2;
			if (k >= 0 && k < `ZCLK_IOWAIT_LEN)
				s = s | IOPAT[k[2:0]];
			if (!s)
			begin
				zeros++;
				if (zeros == want)
					return i + 1;
			end
		end
		return -1;
	endfunction

	task automatic compare(input string what, input int expv, input int actv);
		test_checks++;
		if (expv != actv)
		begin
			$display("[ERROR] %0s %0s interval: expected %0d, actual %0d",
				test_name, what, expv, actv);
			test_errs++;
			error_count++;
		end
	endtask

	task automatic fault(input string msg);
		$display("%0s: %0s", test_name, msg);
		test_errs++;
		error_count++;
	endtask

	always @(posedge fclk or negedge rst_n)
	begin : watch
		logic io_now;
		logic sw;
		int   since_v;
		if (!rst_n)
		begin
			mode = TURBO_35;
			resync = 1'b1;
			since = 0;
			trace = '0;
			io_at = -64;
			io_prev = 1'b0;
			old_rfsh = 1'b1;
			sw_seen = 1'b0;
			prev_stall = 1'b0;
			prev_req = 1'b0;
			prev_ack = 1'b0;
			error_count = 0;
			test_errs = 0;
			test_checks = 0;
		end
		else
		begin
			since_v = since + 1;
			if (prev_stall && (zpos || zneg))
				fault("strobe came out of a stalled cycle");
			if (zpos && zclk_out)
				fault("zclk_out still high after zpos");
			if (zneg && !zclk_out)
				fault("zclk_out still low after zneg");
			if (turbo_ack && !prev_ack && !sw_seen)
				fault("turbo_ack rose without a mode switch at an RFSH edge");
			if (prev_ack && !prev_req && turbo_ack)
				fault("turbo_ack stayed high after turbo_req dropped");
			if (prev_ack && !turbo_ack)
				sw_seen = 1'b0;
			if (zneg && !resync)
				compare("zneg", ref_gap(mode, trace, io_at, 1'b1), since_v);
			if (zpos)
			begin
				if (!resync)
					compare("zpos", ref_gap(mode, trace, io_at, 1'b0), since_v);
				// external non-M1 I/O opens a window only at 14 MHz
				io_now = !iorq_n && m1_n && external_port;
				if (io_now && !io_prev && (mode == TURBO_140 || mode == TURBO_140B))
					io_at = 0;
				else if (io_at > -64)
					io_at = io_at - since_v;
				io_prev = io_now;
				// pending request meets an RFSH falling edge
				sw = turbo_req && !sw_seen && old_rfsh && !rfsh_n;
				old_rfsh = rfsh_n;
				resync = sw;
				if (sw)
				begin
					mode = turbo;
					sw_seen = 1'b1;
				end
				since = 0;
				trace = 64'(zclk_stall);
			end
			else
			begin
				since = since_v;
				if (since_v < 64)
					trace = trace | (64'(zclk_stall) << since_v);
			end
			prev_stall = zclk_stall;
			prev_req = turbo_req;
			prev_ack = turbo_ack;
			if (test_done)
			begin
				$display("test %0s done: %0d checks, %0d errors", test_name, test_checks, test_errs);
				if (test_checks == 0)
					fault("no clock edges were measured");
				test_errs = 0;
				test_checks = 0;
			end
		end
	end

endmodule

/* zclk.f */
+incdir+common
common/zclk_pkg.sv
hdl/clk_phase.sv
zclock/turbo_switch.sv
zclock/io_wait_gen.sv
zclock/zclock.sv
hdl/zclk_top.sv
test/zclk_checker.sv
test/tb_zclk.sv

/* zclock/io_wait_gen.sv */
// 14 MHz external I/O wait window counter and its fixed stall pattern
`timescale 1ns/1ps
`include "zclk_settings.svh"

module io_wait_gen
(
	input  logic            fclk,
	input  logic            rst_n,

	input  logic            zpos,
	input  logic            iorq_n,
	input  logic            m1_n,
	input  logic            external_port,

	input  zclk_pkg::turbo_t int_turbo,

	output logic            io_wait
);

	import zclk_pkg::*;

	// external non-M1 I/O cycle in progress
	logic       io;
	// io as sampled on the previous zpos
	logic       io_r;
	// bit 3 runs the window, bits 2..0 count through it
	logic [3:0] wait_cnt;
	logic [7:0] wait_pat;
	logic       turbo_14;
	logic       start;

	assign io       = ~iorq_n & m1_n & external_port;
	assign turbo_14 = (int_turbo == TURBO_140) || (int_turbo == TURBO_140B);
	assign wait_pat = `ZCLK_IOWAIT_PAT;

	// window starts on the first zpos that sees the I/O term
	assign start = io & ~io_r & zpos & turbo_14;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_r <= 1'b0;
		else if (zpos)
			io_r <= io;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			wait_cnt <= 4'd0;
		else if (start)
			wait_cnt <= 4'b1000;
		else if (wait_cnt[3])
		begin
			// last count ends the window
			if (wait_cnt[2:0] == 3'(`ZCLK_IOWAIT_LEN - 1))
				wait_cnt <= 4'd0;
			else
				wait_cnt <= wait_cnt + 4'd1;
		end
	end

	// pattern lookup, one register stage behind the counter
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_wait <= 1'b0;
		else
			io_wait <= wait_cnt[3] & wait_pat[wait_cnt[2:0]];
	end

endmodule

/* zclock/turbo_switch.sv */
// turbo mode req/ack port that switches the internal mode at the RFSH falling edge
`timescale 1ns/1ps

module turbo_switch
(
	input  logic            fclk,
	input  logic            rst_n,

	input  logic            zpos,
	input  logic            rfsh_n,

	input  zclk_pkg::turbo_t turbo,
	input  logic            turbo_req,
	output logic            turbo_ack,

	output zclk_pkg::turbo_t int_turbo
);

	import zclk_pkg::*;

	// rfsh_n as seen on the previous zpos
	logic old_rfsh_n;
	// request seen, waiting for the refresh edge
	logic pending;
	// mode was loaded in the previous cycle
	logic sw_done;
	// mode load happens this cycle
	logic switch_now;

	// falling edge of RFSH only counts on a zpos, and only with a pending request
	assign switch_now = pending & zpos & old_rfsh_n & ~rfsh_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			old_rfsh_n <= 1'b1;
		else if (zpos)
			old_rfsh_n <= rfsh_n;
	end

	// pending is not re-armed while the current handshake is still closing
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pending <= 1'b0;
			sw_done <= 1'b0;
		end
		else
		begin
			sw_done <= switch_now;
			if (switch_now)
				pending <= 1'b0;
			else if (turbo_req && !turbo_ack && !sw_done)
				pending <= 1'b1;
		end
	end

	// turbo is stable while turbo_req is high
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			int_turbo <= TURBO_35;
		else if (switch_now)
			int_turbo <= turbo;
	end

	// ack rises one cycle after the load and falls one cycle after req drops
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			turbo_ack <= 1'b0;
		else if (sw_done)
			turbo_ack <= 1'b1;
		else if (!turbo_req)
			turbo_ack <= 1'b0;
	end

endmodule

/* zclock/zclock.sv */
// Z80 clock generator with per-speed edge sources, stall gating, zpos, zneg and zclk_out
`timescale 1ns/1ps

module zclock
(
	input  logic            fclk,
	input  logic            rst_n,

	// bus phase strobes
	input  logic            c0,
	input  logic            c2,

	// memory stall from outside and the I/O wait pattern
	input  logic            zclk_stall,
	input  logic            io_wait,

	input  zclk_pkg::turbo_t int_turbo,

	output logic            zpos,
	output logic            zneg,
	// Z80 clock, inverted outside the FPGA
	output logic            zclk_out
);

	import zclk_pkg::*;

	// every other c2 for the 3.5 MHz edges
	logic half_c2;
	// free toggle for 14 MHz, frozen by the stall
	logic clk14_src;
	logic stall;

	logic pre_zpos_35;
	logic pre_zneg_35;
	logic pre_zpos_70;
	logic pre_zneg_70;
	logic pre_zpos_140;
	logic pre_zneg_140;

	// selected edge sources
	logic pre_zpos;
	logic pre_zneg;

	assign stall = zclk_stall | io_wait;

	// 14 MHz, one edge per fclk cycle unless stalled
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	assign pre_zpos_140 = clk14_src;
	assign pre_zneg_140 = ~clk14_src;

	// halve c2
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			half_c2 <= 1'b0;
		else if (c2)
			half_c2 <= ~half_c2;
	end

	// 3.5 MHz alternates zpos and zneg on c2
	assign pre_zpos_35 = c2 & ~half_c2;
	assign pre_zneg_35 = c2 & half_c2;

	// 7 MHz, zpos on c2 and zneg on c0
	assign pre_zpos_70 = c2;
	assign pre_zneg_70 = c0;

	always_comb
	begin
		case (int_turbo)
			TURBO_35:
			begin
				pre_zpos = pre_zpos_35;
				pre_zneg = pre_zneg_35;
			end
			TURBO_70:
			begin
				pre_zpos = pre_zpos_70;
				pre_zneg = pre_zneg_70;
			end
			// both 14 MHz codes
			default:
			begin
				pre_zpos = pre_zpos_140;
				pre_zneg = pre_zneg_140;
			end
		endcase
	end

	// strobes only against the opposite clock level, so edges always alternate
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= ~stall & pre_zpos & zclk_out;
			zneg <= ~stall & pre_zneg & ~zclk_out;
		end
	end

	// half an fclk cycle of lead on the Z80 clock edges
	always_ff @(negedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			zclk_out <= 1'b0;
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

endmodule
